//--- design/acc_pkg.sv
package acc_pkg;

	// sum width, wraps modulo 2^ACC_W
	localparam int ACC_W = 24;

	typedef logic [ACC_W-1:0] acc_t;

	// one sum per output lane, lane o in slice o
	typedef logic [xbar_pkg::NUM_OUT*ACC_W-1:0] acc_bus_t;

endpackage

//--- design/crossbar_one_hot_seq.sv
`timescale 1ns/1ps

module crossbar_one_hot_seq (
	input  logic                 clk,
	input  logic                 i_arst_n,
	route_if.dst                 i_route,
	output xbar_pkg::lane_mask_t o_valid,
	output xbar_pkg::out_bus_t   o_data,
	output logic                 o_last
);
	import xbar_pkg::*;

	// {hit, source index}; hit low when the column is not one-hot
	function automatic logic [SRC_W:0] col_decode(input logic [NUM_IN-1:0] col);
		case (col)
			8'b0000_0001:
			begin
				col_decode = {1'b1, 3'd0};
			end
			8'b0000_0010:
			begin
				col_decode = {1'b1, 3'd1};
			end
			8'b0000_0100:
			begin
				col_decode = {1'b1, 3'd2};
			end
			8'b0000_1000:
			begin
				col_decode = {1'b1, 3'd3};
			end
			8'b0001_0000:
			begin
				col_decode = {1'b1, 3'd4};
			end
			8'b0010_0000:
			begin
				col_decode = {1'b1, 3'd5};
			end
			8'b0100_0000:
			begin
				col_decode = {1'b1, 3'd6};
			end
			8'b1000_0000:
			begin
				col_decode = {1'b1, 3'd7};
			end
			default:
			begin
				col_decode = '0;  // empty or multi-hot column
			end
		endcase
	endfunction

	for (genvar o = 0; o < NUM_OUT; o++)
	begin : g_lane
		logic [NUM_IN-1:0] col;
		logic              hit;
		src_idx_t          sel;
		data_t             word;
		logic              valid_q;
		data_t             data_q;

		// gather this lane's column of the command matrix
		for (genvar k = 0; k < NUM_IN; k++)
		begin : g_col
			assign col[k] = i_route.cmd[k*NUM_OUT + o];
		end

		assign {hit, sel} = col_decode(col);
		assign word = i_route.data[int'(sel)*DATA_W +: DATA_W];

		always_ff @(posedge clk or negedge i_arst_n)
		begin
			if (!i_arst_n)
			begin
				valid_q <= 1'b0;
				data_q  <= '0;
			end
			else if (i_route.en && hit && i_route.valid[sel])
			begin
				valid_q <= 1'b1;
				data_q  <= word;
			end
			else
			begin
				valid_q <= 1'b0;  // disabled lane, invalid source or en low
				data_q  <= '0;
			end
		end

		assign o_valid[o]                = valid_q;
		assign o_data[o*DATA_W +: DATA_W] = data_q;
	end

	// last rides along with the routed beat
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_last <= 1'b0;
		end
		else
		begin
			o_last <= i_route.last;
		end
	end

endmodule

//--- design/dist_acc_top.sv
`timescale 1ns/1ps

module dist_acc_top (
	input  logic                 clk,
	input  logic                 i_arst_n,
	input  logic                 i_en,
	input  xbar_pkg::in_valid_t  i_valid,
	input  xbar_pkg::in_bus_t    i_data,
	input  xbar_pkg::src_bus_t   i_src,
	input  xbar_pkg::lane_mask_t i_lane_en,
	input  logic                 i_last,
	output logic                 o_result_valid,
	output acc_pkg::acc_bus_t    o_result
);
	import xbar_pkg::*;

	// crossbar to accumulator
	lane_mask_t xb_valid;
	out_bus_t   xb_data;
	logic       xb_last;

	route_if route_bus ();

	// stage 1, command decode
	route_decode u_decode (
		.clk       (clk),
		.i_arst_n  (i_arst_n),
		.i_en      (i_en),
		.i_valid   (i_valid),
		.i_data    (i_data),
		.i_src     (i_src),
		.i_lane_en (i_lane_en),
		.i_last    (i_last),
		.o_route   (route_bus.src)
	);

	// stage 2
	crossbar_one_hot_seq u_xbar (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_route  (route_bus.dst),
		.o_valid  (xb_valid),
		.o_data   (xb_data),
		.o_last   (xb_last)
	);

	// stage 3, tile sums
	lane_accumulator u_acc (
		.clk            (clk),
		.i_arst_n       (i_arst_n),
		.i_valid        (xb_valid),
		.i_data         (xb_data),
		.i_last         (xb_last),
		.o_result_valid (o_result_valid),
		.o_result       (o_result)
	);

endmodule

//--- design/lane_accumulator.sv
`timescale 1ns/1ps

module lane_accumulator (
	input  logic                 clk,
	input  logic                 i_arst_n,
	input  xbar_pkg::lane_mask_t i_valid,
	input  xbar_pkg::out_bus_t   i_data,
	input  logic                 i_last,
	output logic                 o_result_valid,
	output acc_pkg::acc_bus_t    o_result
);
	import xbar_pkg::*;
	import acc_pkg::*;

	for (genvar o = 0; o < NUM_OUT; o++)
	begin : g_acc
		data_t word;
		acc_t  addend;
		acc_t  sum_now;
		acc_t  total_q;   // running tile sum
		acc_t  result_q;

		assign word    = i_data[o*DATA_W +: DATA_W];
		assign addend  = i_valid[o] ? acc_t'(word) : '0;  // zero-extended
		assign sum_now = total_q + addend;                // wraps at 2^24

		always_ff @(posedge clk or negedge i_arst_n)
		begin
			if (!i_arst_n)
			begin
				total_q  <= '0;
				result_q <= '0;
			end
			else if (i_last)
			begin
				// tile ends here, this beat included
				result_q <= sum_now;
				total_q  <= '0;
			end
			else
			begin
				total_q <= sum_now;
			end
		end

		assign o_result[o*ACC_W +: ACC_W] = result_q;
	end

	// one cycle per last beat, not held
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_result_valid <= 1'b0;
		end
		else
		begin
			o_result_valid <= i_last;
		end
	end

endmodule

//--- design/route_decode.sv
`timescale 1ns/1ps

module route_decode (
	input  logic                clk,
	input  logic                i_arst_n,
	input  logic                i_en,
	input  xbar_pkg::in_valid_t  i_valid,
	input  xbar_pkg::in_bus_t    i_data,
	input  xbar_pkg::src_bus_t   i_src,
	input  xbar_pkg::lane_mask_t i_lane_en,
	input  logic                i_last,
	route_if.src                o_route
);
	import xbar_pkg::*;

	src_idx_t lane_src [NUM_OUT];
	cmd_t     cmd_next;

	// split the packed source indices per output lane
	for (genvar o = 0; o < NUM_OUT; o++)
	begin : g_src
		assign lane_src[o] = i_src[o*SRC_W +: SRC_W];
	end

	// one bit per enabled lane, none for a disabled one
	always_comb
	begin
		cmd_next = '0;
		for (int o = 0; o < NUM_OUT; o++)
		begin
			if (i_lane_en[o])
			begin
				cmd_next[int'(lane_src[o])*NUM_OUT + o] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_route.en    <= 1'b0;
			o_route.valid <= '0;
			o_route.cmd   <= '0;
			o_route.last  <= 1'b0;
		end
		else
		begin
			o_route.en    <= i_en;
			o_route.valid <= i_valid;
			o_route.cmd   <= cmd_next;
			o_route.last  <= i_last & i_en;  // a last without enable ends nothing
		end
	end

	// data words only matter when en is high downstream
	always_ff @(posedge clk)
	begin
		o_route.data <= i_data;
	end

endmodule

//--- design/route_if.sv
`timescale 1ns/1ps

interface route_if;
	import xbar_pkg::*;

	logic      en;     // registered enable
	in_valid_t valid;  // raw source valids
	in_bus_t   data;
	cmd_t      cmd;    // one-hot column per lane
	logic      last;   // already gated by enable

	// decode side
	modport src (
		output en,
		output valid,
		output data,
		output cmd,
		output last
	);

	// crossbar side
	modport dst (
		input en,
		input valid,
		input data,
		input cmd,
		input last
	);

endinterface

//--- design/xbar_pkg.sv
package xbar_pkg;

	// routing geometry, fixed for this slice
	localparam int NUM_IN  = 8;
	localparam int NUM_OUT = 4;
	localparam int DATA_W  = 16;

	localparam int SRC_W = $clog2(NUM_IN);  // bits to name one source
	localparam int CMD_W = NUM_IN * NUM_OUT;

	// one source word
	typedef logic [DATA_W-1:0] data_t;

	// per-source valid strobes
	typedef logic [NUM_IN-1:0] in_valid_t;

	// source k sits in slice k
	typedef logic [NUM_IN*DATA_W-1:0] in_bus_t;

	typedef logic [SRC_W-1:0] src_idx_t;

	// output lane o picks its source from slice o
	typedef logic [NUM_OUT*SRC_W-1:0] src_bus_t;

	typedef logic [NUM_OUT-1:0] lane_mask_t;

	typedef logic [NUM_OUT*DATA_W-1:0] out_bus_t;

	// bit (src*NUM_OUT + lane) set means src drives lane
	typedef logic [CMD_W-1:0] cmd_t;

endpackage

//--- dv/dist_acc_sva.sv
`timescale 1ns/1ps

module dist_acc_sva (
	input logic                 clk,
	input logic                 i_arst_n,
	input logic                 i_en,
	input xbar_pkg::in_valid_t  i_valid,
	input xbar_pkg::src_bus_t   i_src,
	input xbar_pkg::lane_mask_t i_lane_en,
	input logic                 i_last,
	input xbar_pkg::lane_mask_t xb_valid,
	input xbar_pkg::out_bus_t   xb_data,
	input logic                 xb_last,
	input logic                 o_result_valid,
	input acc_pkg::acc_bus_t    o_result
);
	import xbar_pkg::*;

	// lane valid two cycles after an enabled lane picked a valid source
	for (genvar o = 0; o < NUM_OUT; o++)
	begin : g_lane
		a_lane_valid_src: assert property (@(posedge clk) disable iff (!i_arst_n)
			xb_valid[o] |-> $past(i_en && i_lane_en[o]
				&& i_valid[i_src[o*SRC_W +: SRC_W]], 2))
			else $error("crossbar lane %0d valid without an enabled lane and valid source", o);
	end

	// a second result cycle only follows a second enabled last at the inputs
	a_result_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_result_valid |=> (!o_result_valid || $past(i_en && i_last, 3)))
		else $error("o_result_valid held without a consecutive last beat");

	a_reset_quiet: assert property (@(posedge clk)
		!i_arst_n |-> (!o_result_valid && o_result == '0 && xb_valid == '0
			&& xb_data == '0 && !xb_last))
		else $error("outputs not cleared while reset is asserted");

endmodule

bind dist_acc_top dist_acc_sva u_sva (
	.clk            (clk),
	.i_arst_n       (i_arst_n),
	.i_en           (i_en),
	.i_valid        (i_valid),
	.i_src          (i_src),
	.i_lane_en      (i_lane_en),
	.i_last         (i_last),
	.xb_valid       (xb_valid),
	.xb_data        (xb_data),
	.xb_last        (xb_last),
	.o_result_valid (o_result_valid),
	.o_result       (o_result)
);

//--- dv/dist_acc_tb.sv
`timescale 1ns/1ps

module dist_acc_tb;
	import xbar_pkg::*;
	import acc_pkg::*;

	localparam int DRAIN_LIMIT = 50;  // cycles

	logic       clk;
	logic       i_arst_n;
	logic       i_en;
	in_valid_t  i_valid;
	in_bus_t    i_data;
	src_bus_t   i_src;
	lane_mask_t i_lane_en;
	logic       i_last;
	logic       o_result_valid;
	acc_bus_t   o_result;

	acc_t       model_sum [NUM_OUT];
	acc_bus_t   exp_q [$];    // tile sums waiting for the DUT
	logic [2:0] last_pipe;    // enabled lasts still in the pipeline
	int         value_errs;
	int         other_errs;
	int         tiles_seen;

	dist_acc_top u_dut (
		.clk            (clk),
		.i_arst_n       (i_arst_n),
		.i_en           (i_en),
		.i_valid        (i_valid),
		.i_data         (i_data),
		.i_src          (i_src),
		.i_lane_en      (i_lane_en),
		.i_last         (i_last),
		.o_result_valid (o_result_valid),
		.o_result       (o_result)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#4 clk = ~clk;
		end
	end

	task automatic check_acc(input acc_t want, input acc_t got, input string name);
		if (got !== want)
		begin
			value_errs++;
			$display("Fail %0t: %s expected %0h got %0h", $time, name, want, got);
		end
	endtask

	task automatic check_bit(input logic want, input logic got, input string name);
		if (got !== want)
		begin
			value_errs++;
			$display("Fail %0t: %s expected %b got %b", $time, name, want, got);
		end
	endtask

	function automatic bit chance(input int pct);
		return ($urandom % 100) < pct;
	endfunction

	function automatic in_valid_t rand_valid(input int pct);
		in_valid_t v;
		for (int k = 0; k < NUM_IN; k++)
		begin
			v[k] = chance(pct);
		end
		return v;
	endfunction

	function automatic lane_mask_t rand_lanes(input int pct);
		lane_mask_t m;
		for (int o = 0; o < NUM_OUT; o++)
		begin
			m[o] = chance(pct);
		end
		return m;
	endfunction

	function automatic in_bus_t rand_data(input bit big);
		in_bus_t d;
		data_t   w;
		for (int k = 0; k < NUM_IN; k++)
		begin
			w = data_t'($urandom);
			if (big)
				w[DATA_W-1:DATA_W-4] = 4'hf;  // push sums toward wraparound
			d[k*DATA_W +: DATA_W] = w;
		end
		return d;
	endfunction

	// bcast gives every lane the same source
	function automatic src_bus_t rand_src(input bit bcast);
		src_bus_t s;
		src_idx_t one;
		one = src_idx_t'($urandom % NUM_IN);
		for (int o = 0; o < NUM_OUT; o++)
		begin
			s[o*SRC_W +: SRC_W] = bcast ? one : src_idx_t'($urandom % NUM_IN);
		end
		return s;
	endfunction

	task automatic drive_idle();
		@(negedge clk);
		i_en      = 1'b0;
		i_last    = 1'b0;
		i_valid   = '0;
		i_lane_en = '0;
	endtask

	// last beat is always enabled and closes the tile
	task automatic run_tile(input int beats, input int valid_pct, input int lane_pct,
		input int en_pct, input lane_mask_t keep, input bit bcast, input bit big);
		for (int b = 0; b < beats; b++)
		begin
			bit final_beat;
			@(negedge clk);
			final_beat = (b == beats - 1);
			i_en      = final_beat ? 1'b1 : chance(en_pct);
			i_valid   = rand_valid(valid_pct);
			i_data    = rand_data(big);
			i_src     = rand_src(bcast);
			i_lane_en = rand_lanes(lane_pct) & keep;
			if (final_beat)
				i_last = 1'b1;
			else
				i_last = !i_en && chance(50);  // stray last while disabled
		end
	endtask

	task automatic wait_drain();
		int n;
		drive_idle();
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			other_errs++;
			$display("%0t: timed out with %0d tile results never seen", $time, exp_q.size());
		end
	endtask

	// reference model sampled where the DUT samples its inputs
	always @(posedge clk)
	begin : b_model
		acc_bus_t done;
		src_idx_t s;
		if (!i_arst_n)
		begin
			for (int o = 0; o < NUM_OUT; o++)
				model_sum[o] = '0;
			last_pipe = '0;
		end
		else
		begin
			last_pipe = {last_pipe[1:0], i_en & i_last};
			if (i_en)
			begin
				for (int o = 0; o < NUM_OUT; o++)
				begin
					s = i_src[o*SRC_W +: SRC_W];
					if (i_lane_en[o] && i_valid[s])
						model_sum[o] = model_sum[o] + acc_t'(i_data[int'(s)*DATA_W +: DATA_W]);
				end
				if (i_last)
				begin
					for (int o = 0; o < NUM_OUT; o++)
					begin
						done[o*ACC_W +: ACC_W] = model_sum[o];
						model_sum[o] = '0;
					end
					exp_q.push_back(done);
				end
			end
		end
	end

	always @(negedge clk)
	begin : b_monitor
		acc_bus_t want;
		check_bit(last_pipe[2], o_result_valid, "o_result_valid");
		if (o_result_valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				other_errs++;
				$display("%0t: result arrived with no tile expected", $time);
			end
			else
			begin
				want = exp_q.pop_front();
				for (int o = 0; o < NUM_OUT; o++)
					check_acc(want[o*ACC_W +: ACC_W], o_result[o*ACC_W +: ACC_W],
						$sformatf("o_result[%0d]", o));
				tiles_seen++;
			end
		end
	end

	initial
	begin : b_main
		int unused_seed;
		value_errs = 0;
		other_errs = 0;
		tiles_seen = 0;
		last_pipe  = '0;
		i_arst_n   = 1'b1;
		i_en       = 1'b0;
		i_valid    = '0;
		i_data     = '0;
		i_src      = '0;
		i_lane_en  = '0;
		i_last     = 1'b0;
		unused_seed = $urandom(46);
		#1 i_arst_n = 1'b0;
		// busy inputs while in reset must not leak into the first tile
		repeat (2)
		begin
			@(negedge clk);
			i_en      = 1'b1;
			i_valid   = '1;
			i_data    = rand_data(1'b0);
			i_src     = rand_src(1'b0);
			i_lane_en = '1;
			i_last    = chance(50);
		end
		@(negedge clk);
		i_arst_n = 1'b1;
		i_en     = 1'b0;
		i_last   = 1'b0;
		repeat (20)
			run_tile(1 + $urandom % 8, 100, 100, 100, '1, 1'b0, 1'b0);
		wait_drain();
		repeat (20)
			run_tile(1 + $urandom % 8, 60, 70, 100, '1, 1'b0, 1'b0);
		run_tile(6, 100, 100, 100, 4'b1011, 1'b0, 1'b0);  // lane 2 off all tile
		wait_drain();
		repeat (20)
			run_tile(2 + $urandom % 10, 80, 90, 50, '1, 1'b0, 1'b0);
		wait_drain();
		repeat (10)
			run_tile(1 + $urandom % 4, 100, 100, 100, '1, 1'b1, 1'b0);
		repeat (16)
			run_tile(1, 90, 100, 100, '1, 1'b0, 1'b0);
		wait_drain();
		repeat (2)
			run_tile(400, 100, 100, 100, '1, 1'b0, 1'b1);
		wait_drain();
		repeat (5)
			@(negedge clk);
		if (tiles_seen == 0)
		begin
			other_errs++;
			$display("no tile result was ever checked");
		end
		$display("tiles %0d, value errors %0d, other errors %0d", tiles_seen, value_errs,
			other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verilog.f
design/xbar_pkg.sv
design/acc_pkg.sv
design/route_if.sv
design/route_decode.sv
design/crossbar_one_hot_seq.sv
design/lane_accumulator.sv
design/dist_acc_top.sv
dv/dist_acc_sva.sv
dv/dist_acc_tb.sv
